// File: include/chacha_params.svh
`ifndef CHACHA_PARAMS_SVH
`define CHACHA_PARAMS_SVH

`define CHACHA_WORD_W        32
`define CHACHA_BLOCK_WORDS   16
`define CHACHA_DOUBLE_ROUNDS 10

// wishbone word addresses
`define CHACHA_ADR_KEY0      0
`define CHACHA_ADR_COUNTER   8
`define CHACHA_ADR_NONCE0    9
`define CHACHA_ADR_CTRL      12
`define CHACHA_ADR_W         4

`define CHACHA_IN_DEPTH      32
`define CHACHA_OUT_DEPTH     32

// "expand 32-byte k"
`define CHACHA_CONST0        32'h6170_7865
`define CHACHA_CONST1        32'h3320_646e
`define CHACHA_CONST2        32'h7962_2d32
`define CHACHA_CONST3        32'h6b20_6574

`endif

// File: logic/chacha_pkg.sv
package chacha_pkg;

  `include "chacha_params.svh"

  typedef logic [`CHACHA_WORD_W-1:0] word_t;

  // word 0 sits in the low bits
  typedef word_t [`CHACHA_BLOCK_WORDS-1:0] block_t;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`CHACHA_ADR_W-1:0] adr;
    word_t                   wdat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t rdat;
  } wb_rsp_t;

  typedef struct packed {
    word_t [7:0] key;
    word_t       counter;
    word_t [2:0] nonce;
    logic        start;   // one-cycle pulse
  } chacha_cfg_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } out_beat_t;

endpackage

// File: logic/chacha_regs.sv
`timescale 1ns/1ps
`include "chacha_params.svh"

module chacha_regs
  import chacha_pkg::*;
(
  input  logic        aclk,
  input  logic        areset_n,
  input  wb_req_t     i_wb,
  output wb_rsp_t     o_wb,
  output chacha_cfg_t o_cfg
);

  localparam logic [`CHACHA_ADR_W-1:0] ADR_KEY0   = `CHACHA_ADR_KEY0;
  localparam logic [`CHACHA_ADR_W-1:0] ADR_CTR    = `CHACHA_ADR_COUNTER;
  localparam logic [`CHACHA_ADR_W-1:0] ADR_NONCE0 = `CHACHA_ADR_NONCE0;
  localparam logic [`CHACHA_ADR_W-1:0] ADR_CTRL   = `CHACHA_ADR_CTRL;

  logic                     ack;
  logic                     req;
  logic                     wr;
  logic                     ctrl_bit;
  logic                     is_key;
  logic                     is_ctr;
  logic                     is_nonce;
  logic                     is_ctrl;
  logic [`CHACHA_ADR_W-1:0] key_off;
  logic [`CHACHA_ADR_W-1:0] nonce_off;
  word_t                    rd_mux;
  word_t                    rdat;
  chacha_cfg_t              cfg;

  assign req = i_wb.cyc && i_wb.stb && !ack;  // first cycle of a transfer
  assign wr  = req && i_wb.we;

  // wrapping offsets catch both range bounds
  assign key_off   = i_wb.adr - ADR_KEY0;
  assign nonce_off = i_wb.adr - ADR_NONCE0;
  assign is_key    = key_off < `CHACHA_ADR_W'd8;
  assign is_nonce  = nonce_off < `CHACHA_ADR_W'd3;
  assign is_ctr    = i_wb.adr == ADR_CTR;
  assign is_ctrl   = i_wb.adr == ADR_CTRL;

  always_comb begin
    rd_mux = '0;  // unmapped reads zero
    if (is_key) begin
      rd_mux = cfg.key[key_off[2:0]];
    end else if (is_ctr) begin
      rd_mux = cfg.counter;
    end else if (is_nonce) begin
      rd_mux = cfg.nonce[nonce_off[1:0]];
    end else if (is_ctrl) begin
      rd_mux = {{(`CHACHA_WORD_W-1){1'b0}}, ctrl_bit};
    end
  end

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      ack      <= 1'b0;
      rdat     <= '0;
      cfg      <= '0;
      ctrl_bit <= 1'b0;
    end else begin
      ack       <= req;
      cfg.start <= wr && is_ctrl && i_wb.wdat[0];  // high on the ack cycle
      if (req) begin
        rdat <= rd_mux;
      end
      if (wr) begin
        if (is_key)   cfg.key[key_off[2:0]]     <= i_wb.wdat;
        if (is_ctr)   cfg.counter               <= i_wb.wdat;
        if (is_nonce) cfg.nonce[nonce_off[1:0]] <= i_wb.wdat;
        if (is_ctrl)  ctrl_bit                  <= i_wb.wdat[0];
      end
    end
  end

  assign o_wb.ack  = ack;
  assign o_wb.rdat = rdat;
  assign o_cfg     = cfg;

endmodule

// File: logic/chacha_block_core.sv
`timescale 1ns/1ps
`include "chacha_params.svh"

module chacha_block_core
  import chacha_pkg::*;
(
  input  logic        aclk,
  input  logic        areset_n,
  input  chacha_cfg_t i_cfg,
  output logic        o_ks_valid,
  input  logic        i_ks_ready,
  output block_t      o_ks_block
);

  localparam int HALF_ROUNDS = 2 * `CHACHA_DOUBLE_ROUNDS;
  localparam int CNT_W       = $clog2(HALF_ROUNDS);
  localparam int CTR_IDX     = 12;  // block counter word

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ROUND,
    PH_ADD
  } phase_t;

  phase_t           phase;
  logic [CNT_W-1:0] rnd_cnt;
  logic             ks_valid;
  logic             add_fire;
  block_t           work;
  block_t           orig;
  block_t           ks_block;
  block_t           init_blk;
  block_t           next_orig;

  function automatic word_t rotl(word_t x, int n);
    return (x << n) | (x >> (`CHACHA_WORD_W - n));
  endfunction

  function automatic block_t quarter(block_t s, int a, int b, int c, int d);
    block_t r;
    r    = s;
    r[a] = r[a] + r[b];
    r[d] = rotl(r[d] ^ r[a], 16);
    r[c] = r[c] + r[d];
    r[b] = rotl(r[b] ^ r[c], 12);
    r[a] = r[a] + r[b];
    r[d] = rotl(r[d] ^ r[a], 8);
    r[c] = r[c] + r[d];
    r[b] = rotl(r[b] ^ r[c], 7);
    return r;
  endfunction

  // the four quarter rounds of a half touch disjoint words
  function automatic block_t half_round(block_t s, logic diag);
    block_t r;
    r = s;
    for (int i = 0; i < 4; i++) begin
      if (diag) begin
        r = quarter(r, i, 4 + (i + 1) % 4, 8 + (i + 2) % 4, 12 + (i + 3) % 4);
      end else begin
        r = quarter(r, i, 4 + i, 8 + i, 12 + i);
      end
    end
    return r;
  endfunction

  function automatic block_t add_blocks(block_t x, block_t y);
    block_t r;
    for (int i = 0; i < `CHACHA_BLOCK_WORDS; i++) begin
      r[i] = x[i] + y[i];
    end
    return r;
  endfunction

  always_comb begin
    init_blk[0] = `CHACHA_CONST0;
    init_blk[1] = `CHACHA_CONST1;
    init_blk[2] = `CHACHA_CONST2;
    init_blk[3] = `CHACHA_CONST3;
    for (int i = 0; i < 8; i++) begin
      init_blk[4 + i] = i_cfg.key[i];
    end
    init_blk[CTR_IDX] = i_cfg.counter;
    for (int i = 0; i < 3; i++) begin
      init_blk[13 + i] = i_cfg.nonce[i];
    end
  end

  always_comb begin
    next_orig          = orig;
    next_orig[CTR_IDX] = orig[CTR_IDX] + 1'b1;
  end

  // add waits until the output slot is free or leaving
  assign add_fire = (phase == PH_ADD) && (!ks_valid || i_ks_ready);

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      phase    <= PH_IDLE;
      rnd_cnt  <= '0;
      ks_valid <= 1'b0;
    end else if (i_cfg.start) begin
      phase    <= PH_ROUND;  // abort and reload
      rnd_cnt  <= '0;
      ks_valid <= 1'b0;
    end else begin
      if (ks_valid && i_ks_ready) begin
        ks_valid <= 1'b0;
      end
      case (phase)
        PH_ROUND: begin
          if (rnd_cnt == CNT_W'(HALF_ROUNDS - 1)) begin
            phase   <= PH_ADD;
            rnd_cnt <= '0;
          end else begin
            rnd_cnt <= rnd_cnt + 1'b1;
          end
        end
        PH_ADD: begin
          if (add_fire) begin
            ks_valid <= 1'b1;
            phase    <= PH_ROUND;  // next block starts right away
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (i_cfg.start) begin
      orig <= init_blk;
      work <= init_blk;
    end else if (phase == PH_ROUND) begin
      work <= half_round(work, rnd_cnt[0]);  // odd steps are diagonal
    end else if (add_fire) begin
      ks_block <= add_blocks(work, orig);
      orig     <= next_orig;
      work     <= next_orig;
    end
  end

  assign o_ks_valid = ks_valid;
  assign o_ks_block = ks_block;

endmodule

// File: logic/chacha_fifo.sv
`timescale 1ns/1ps

module chacha_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [31:0]
) (
  input  logic     aclk,
  input  logic     areset_n,
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign o_ready = count != CNT_W'(DEPTH);
  assign o_valid = count != '0;
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;
  assign o_data  = mem[rd_ptr];

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;  // head reads clean while empty
      end
    end else begin
      if (push) begin
        mem[wr_ptr] <= i_data;
        wr_ptr      <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// File: logic/chacha_mixer.sv
`timescale 1ns/1ps
`include "chacha_params.svh"

module chacha_mixer
  import chacha_pkg::*;
(
  input  logic      aclk,
  input  logic      areset_n,
  input  logic      i_ks_valid,
  output logic      o_ks_ready,
  input  block_t    i_ks_block,
  input  logic      i_in_valid,
  output logic      o_in_ready,
  input  word_t     i_in_data,
  output logic      o_out_valid,
  input  logic      i_out_ready,
  output out_beat_t o_out_beat
);

  localparam int IDX_W = $clog2(`CHACHA_BLOCK_WORDS);

  block_t           ks;
  logic             have;
  logic [IDX_W-1:0] idx;
  logic             fire;
  logic             last;
  logic             ks_take;

  // a block is taken only once data waits, so a new start
  // never finds a block of the old key parked here
  assign o_ks_ready = !have && i_in_valid;
  assign ks_take    = i_ks_valid && o_ks_ready;

  assign fire        = have && i_in_valid && i_out_ready;
  assign last        = idx == IDX_W'(`CHACHA_BLOCK_WORDS - 1);
  assign o_in_ready  = have && i_out_ready;
  assign o_out_valid = have && i_in_valid;

  assign o_out_beat.data = i_in_data ^ ks[idx];
  assign o_out_beat.last = last;

  always_ff @(posedge aclk or negedge areset_n) begin
    if (!areset_n) begin
      have <= 1'b0;
      idx  <= '0;
    end else if (ks_take) begin
      have <= 1'b1;
      idx  <= '0;
    end else if (fire) begin
      idx <= idx + 1'b1;
      if (last) begin
        have <= 1'b0;  // block used up
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ks_take) begin
      ks <= i_ks_block;
    end
  end

endmodule

// File: logic/chacha_top.sv
`timescale 1ns/1ps
`include "chacha_params.svh"

module chacha_top
  import chacha_pkg::*;
(
  input  logic    aclk,
  input  logic    areset_n,
  input  wb_req_t i_wb,
  output wb_rsp_t o_wb,
  input  logic    i_tvalid,
  output logic    o_tready,
  input  word_t   i_tdata,
  output logic    o_tvalid,
  input  logic    i_tready,
  output word_t   o_tdata,
  output logic    o_tlast
);

  chacha_cfg_t cfg;
  logic        ks_valid;
  logic        ks_ready;
  block_t      ks_block;
  logic        in_valid;
  logic        in_ready;
  word_t       in_data;
  logic        mix_valid;
  logic        mix_ready;
  out_beat_t   mix_beat;
  out_beat_t   out_beat;

  chacha_regs u_regs (
    .aclk     (aclk),
    .areset_n (areset_n),
    .i_wb     (i_wb),
    .o_wb     (o_wb),
    .o_cfg    (cfg)
  );

  chacha_block_core u_core (
    .aclk       (aclk),
    .areset_n   (areset_n),
    .i_cfg      (cfg),
    .o_ks_valid (ks_valid),
    .i_ks_ready (ks_ready),
    .o_ks_block (ks_block)
  );

  chacha_fifo #(
    .DEPTH     (`CHACHA_IN_DEPTH),
    .payload_t (word_t)
  ) u_in_fifo (
    .aclk     (aclk),
    .areset_n (areset_n),
    .i_valid  (i_tvalid),
    .o_ready  (o_tready),
    .i_data   (i_tdata),
    .o_valid  (in_valid),
    .i_ready  (in_ready),
    .o_data   (in_data)
  );

  chacha_mixer u_mixer (
    .aclk        (aclk),
    .areset_n    (areset_n),
    .i_ks_valid  (ks_valid),
    .o_ks_ready  (ks_ready),
    .i_ks_block  (ks_block),
    .i_in_valid  (in_valid),
    .o_in_ready  (in_ready),
    .i_in_data   (in_data),
    .o_out_valid (mix_valid),
    .i_out_ready (mix_ready),
    .o_out_beat  (mix_beat)
  );

  chacha_fifo #(
    .DEPTH     (`CHACHA_OUT_DEPTH),
    .payload_t (out_beat_t)
  ) u_out_fifo (
    .aclk     (aclk),
    .areset_n (areset_n),
    .i_valid  (mix_valid),
    .o_ready  (mix_ready),
    .i_data   (mix_beat),
    .o_valid  (o_tvalid),
    .i_ready  (i_tready),
    .o_data   (out_beat)
  );

  assign o_tdata = out_beat.data;
  assign o_tlast = out_beat.last;

endmodule

// File: test/chacha_assertions.sv
`timescale 1ns/1ps

module chacha_assertions
  import chacha_pkg::*;
(
  input  logic    aclk,
  input  logic    areset_n,
  input  wb_req_t i_wb_req,
  input  wb_rsp_t i_wb_rsp,
  input  logic    i_tvalid,
  input  logic    i_tready,
  input  word_t   i_tdata,
  input  logic    i_tlast
);

  int fail_count = 0;  // read by the testbench at the end

  stalled_beat_holds: assert property (@(posedge aclk) disable iff (!areset_n)
    i_tvalid && !i_tready |=> i_tvalid && $stable(i_tdata) && $stable(i_tlast))
  else begin
    $error("output beat changed while stalled");
    fail_count++;
  end

  ack_one_cycle: assert property (@(posedge aclk) disable iff (!areset_n)
    i_wb_rsp.ack |=> !i_wb_rsp.ack)
  else begin
    $error("wishbone ack longer than one cycle");
    fail_count++;
  end

  // ack answers a request seen on the cycle before
  ack_needs_request: assert property (@(posedge aclk) disable iff (!areset_n)
    i_wb_rsp.ack |-> $past(i_wb_req.cyc && i_wb_req.stb))
  else begin
    $error("wishbone ack without cyc and stb");
    fail_count++;
  end

endmodule

// File: test/chacha_clk_gen.sv
`timescale 1ns/1ps

module chacha_clk_gen #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 2
) (
  output logic aclk,
  output logic areset_n
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2.0) aclk = ~aclk;
  end

  initial begin
    areset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    areset_n = 1'b1;  // release away from the rising edge
  end

endmodule

// File: test/chacha_tb.sv
`timescale 1ns/1ps
`include "chacha_params.svh"

module chacha_tb
  import chacha_pkg::*;
();

  typedef struct packed {
    chacha_cfg_t cfg;
    logic [7:0]  blocks;
    logic        stall;      // random low periods on output ready
    logic        zero_data;
  } test_row_t;

  localparam int NUM_ROWS = 4;
  localparam int WORDS    = `CHACHA_BLOCK_WORDS;

  logic      aclk;
  logic      areset_n;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  logic      in_tvalid;
  logic      in_tready;
  word_t     in_tdata;
  logic      out_tvalid;
  logic      out_tready;
  word_t     out_tdata;
  logic      out_tlast;
  test_row_t rows [NUM_ROWS];
  string     names [NUM_ROWS];
  word_t     pt_q [$];
  out_beat_t exp_q [$];
  integer    seed = 32'h8a817cc0;
  int        errors = 0;
  int        cycles = 0;
  int        cycle_limit = 0;
  word_t     rd;

  chacha_clk_gen u_clk_gen (
    .aclk     (aclk),
    .areset_n (areset_n)
  );

  chacha_top i_chacha_top (
    .aclk     (aclk),
    .areset_n (areset_n),
    .i_wb     (wb_req),
    .o_wb     (wb_rsp),
    .i_tvalid (in_tvalid),
    .o_tready (in_tready),
    .i_tdata  (in_tdata),
    .o_tvalid (out_tvalid),
    .i_tready (out_tready),
    .o_tdata  (out_tdata),
    .o_tlast  (out_tlast)
  );

  bind chacha_top chacha_assertions u_assertions (
    .aclk     (aclk),
    .areset_n (areset_n),
    .i_wb_req (i_wb),
    .i_wb_rsp (o_wb),
    .i_tvalid (o_tvalid),
    .i_tready (i_tready),
    .i_tdata  (o_tdata),
    .i_tlast  (o_tlast)
  );

  function automatic word_t rol(word_t v, int n);
    return (v << n) | (v >> (32 - n));
  endfunction

  function automatic block_t qr(block_t s, int a, int b, int c, int d);
    word_t va;
    word_t vb;
    word_t vc;
    word_t vd;
    va = s[a];
    vb = s[b];
    vc = s[c];
    vd = s[d];
    va = va + vb;
    vd = rol(vd ^ va, 16);
    vc = vc + vd;
    vb = rol(vb ^ vc, 12);
    va = va + vb;
    vd = rol(vd ^ va, 8);
    vc = vc + vd;
    vb = rol(vb ^ vc, 7);
    s[a] = va;
    s[b] = vb;
    s[c] = vc;
    s[d] = vd;
    return s;
  endfunction

  // reference keystream block, rfc 7539 section 2.3
  function automatic block_t ref_block(chacha_cfg_t cfg, word_t ctr);
    block_t init;
    block_t x;
    block_t res;
    init[0] = 32'h61707865;
    init[1] = 32'h3320646e;
    init[2] = 32'h79622d32;
    init[3] = 32'h6b206574;
    for (int i = 0; i < 8; i++) init[4 + i] = cfg.key[i];
    init[12] = ctr;
    for (int i = 0; i < 3; i++) init[13 + i] = cfg.nonce[i];
    x = init;
    for (int r = 0; r < `CHACHA_DOUBLE_ROUNDS; r++) begin
      x = qr(x, 0, 4, 8, 12);  // columns
      x = qr(x, 1, 5, 9, 13);
      x = qr(x, 2, 6, 10, 14);
      x = qr(x, 3, 7, 11, 15);
      x = qr(x, 0, 5, 10, 15);  // diagonals
      x = qr(x, 1, 6, 11, 12);
      x = qr(x, 2, 7, 8, 13);
      x = qr(x, 3, 4, 9, 14);
    end
    for (int i = 0; i < WORDS; i++) res[i] = x[i] + init[i];
    return res;
  endfunction

  task automatic check_value(input string test, input string what, input word_t expected,
                             input word_t actual);
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s %s: expected %08h actual %08h", test, what, expected, actual);
    end
  endtask

  task automatic wb_access(input logic we, input int adr, input word_t wdat,
                           output word_t rdat);
    int waited;
    @(negedge aclk);
    wb_req.cyc  = 1'b1;
    wb_req.stb  = 1'b1;
    wb_req.we   = we;
    wb_req.adr  = adr[`CHACHA_ADR_W-1:0];
    wb_req.wdat = wdat;
    waited = 0;
    do begin
      @(negedge aclk);
      waited++;
    end while (!wb_rsp.ack && waited < 8);
    if (!wb_rsp.ack) begin
      errors++;
      $display("no wishbone ack for the access at address %0d", adr);
    end
    rdat = wb_rsp.rdat;
    wb_req = '0;
  endtask

  task automatic wb_write(input int adr, input word_t dat);
    word_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input int adr, output word_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic load_table();
    rows[0] = '0;
    names[0] = "rfc7539_block";
    for (int i = 0; i < 8; i++) begin
      rows[0].cfg.key[i] = {8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)};
    end
    rows[0].cfg.counter  = 32'h1;
    rows[0].cfg.nonce[0] = 32'h0900_0000;
    rows[0].cfg.nonce[1] = 32'h4a00_0000;
    rows[0].blocks       = 8'd1;
    rows[0].zero_data    = 1'b1;
    names[1] = "three_blocks";
    names[2] = "back_pressure";
    names[3] = "rekey_after_drain";
    for (int r = 1; r < NUM_ROWS; r++) begin
      rows[r] = '0;
      for (int i = 0; i < 8; i++) rows[r].cfg.key[i] = $random(seed);
      for (int i = 0; i < 3; i++) rows[r].cfg.nonce[i] = $random(seed);
    end
    rows[1].cfg.counter = 32'h0;
    rows[1].blocks      = 8'd3;
    rows[2].cfg.counter = 32'hffff_ffff;  // counter wraps inside the row
    rows[2].blocks      = 8'd2;
    rows[2].stall       = 1'b1;
    rows[3].cfg.counter = 32'h0000_0100;
    rows[3].blocks      = 8'd2;
  endtask

  task automatic config_and_start(input int r);
    for (int i = 0; i < 8; i++) wb_write(`CHACHA_ADR_KEY0 + i, rows[r].cfg.key[i]);
    wb_write(`CHACHA_ADR_COUNTER, rows[r].cfg.counter);
    for (int i = 0; i < 3; i++) wb_write(`CHACHA_ADR_NONCE0 + i, rows[r].cfg.nonce[i]);
    for (int i = 0; i < 8; i++) begin
      wb_read(`CHACHA_ADR_KEY0 + i, rd);
      check_value(names[r], $sformatf("key %0d readback", i), rows[r].cfg.key[i], rd);
    end
    wb_read(`CHACHA_ADR_COUNTER, rd);
    check_value(names[r], "counter readback", rows[r].cfg.counter, rd);
    for (int i = 0; i < 3; i++) begin
      wb_read(`CHACHA_ADR_NONCE0 + i, rd);
      check_value(names[r], $sformatf("nonce %0d readback", i), rows[r].cfg.nonce[i], rd);
    end
    wb_write(`CHACHA_ADR_CTRL, 32'h1);
    wb_read(`CHACHA_ADR_CTRL, rd);
    check_value(names[r], "ctrl readback", 32'h1, rd);
  endtask

  task automatic build_expected(input int r);
    block_t    ks;
    word_t     pt;
    out_beat_t beat;
    for (int b = 0; b < rows[r].blocks; b++) begin
      ks = ref_block(rows[r].cfg, rows[r].cfg.counter + b);
      if (r == 0 && b == 0) check_value(names[r], "model word 0", 32'he4e7f110, ks[0]);
      for (int w = 0; w < WORDS; w++) begin
        pt = rows[r].zero_data ? '0 : $random(seed);
        beat.data = pt ^ ks[w];
        beat.last = w == WORDS - 1;
        pt_q.push_back(pt);
        exp_q.push_back(beat);
      end
    end
  endtask

  task automatic send_words();
    int idx;
    idx = 0;
    while (idx < pt_q.size()) begin
      @(negedge aclk);
      in_tvalid = 1'b1;
      in_tdata  = pt_q[idx];
      if (in_tready) idx++;  // taken on the next rising edge
    end
    @(negedge aclk);
    in_tvalid = 1'b0;
    pt_q.delete();
  endtask

  task automatic receive_words(input int r);
    word_t     rnd;
    out_beat_t exp;
    int        idx;
    idx = 0;
    while (idx < rows[r].blocks * WORDS) begin
      @(negedge aclk);
      rnd = $random(seed);
      out_tready = rows[r].stall ? (rnd[0] | rnd[1]) : 1'b1;
      if (out_tready && out_tvalid) begin
        exp = exp_q.pop_front();
        check_value(names[r], $sformatf("word %0d data", idx), exp.data, out_tdata);
        check_value(names[r], $sformatf("word %0d last", idx), word_t'(exp.last),
                    word_t'(out_tlast));
        idx++;
      end
    end
    @(negedge aclk);
    out_tready = 1'b0;
  endtask

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    wb_req     = '0;
    in_tvalid  = 1'b0;
    in_tdata   = '0;
    out_tready = 1'b0;
    load_table();
    cycle_limit = 200;
    for (int r = 0; r < NUM_ROWS; r++) cycle_limit += 100 * rows[r].blocks;
    wait (areset_n === 1'b1);

    @(negedge aclk);
    check_value("after_reset", "o_tvalid", 32'h0, word_t'(out_tvalid));
    check_value("after_reset", "o_tlast", 32'h0, word_t'(out_tlast));
    check_value("after_reset", "o_tready", 32'h1, word_t'(in_tready));
    check_value("after_reset", "ack", 32'h0, word_t'(wb_rsp.ack));

    wb_write(`CHACHA_ADR_CTRL + 1, 32'hdead_beef);  // unmapped
    wb_write(`CHACHA_ADR_CTRL + 3, 32'h1234_5678);
    wb_read(`CHACHA_ADR_CTRL + 1, rd);
    check_value("unmapped", "address 13 read", 32'h0, rd);
    wb_read(`CHACHA_ADR_CTRL + 3, rd);
    check_value("unmapped", "address 15 read", 32'h0, rd);

    for (int r = 0; r < NUM_ROWS; r++) begin
      config_and_start(r);
      build_expected(r);
      fork
        send_words();
        receive_words(r);
      join
      repeat (4) @(negedge aclk);
      if (out_tvalid) begin
        errors++;
        $display("extra output word after the end of test %s", names[r]);
      end
    end

    $display("errors: %0d checks, %0d assertions", errors,
             i_chacha_top.u_assertions.fail_count);
    if (errors == 0 && i_chacha_top.u_assertions.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: chacha_top.f
+incdir+include
logic/chacha_pkg.sv
logic/chacha_regs.sv
logic/chacha_block_core.sv
logic/chacha_fifo.sv
logic/chacha_mixer.sv
logic/chacha_top.sv
test/chacha_assertions.sv
test/chacha_clk_gen.sv
test/chacha_tb.sv
